/* tests/zx_ula_vectors.txt */
# test access address data kd tape_in joy machine, all numbers in hex
# machine 0 is the 48K model and 1 the 128K model
fe_wr io_wr 00FE 1D 00 0 00 1
fe_rd io_rd 00FE 00 0A 1 00 1
kemp_rd io_rd 001F 00 1F 0 15 1
undec_rd io_rd 00FF 00 1F 1 1F 1
rom128_rd mem_rd 0123 00 1F 0 00 1
page_wr io_wr 7FFD 13 1F 0 00 1
ram_c000_rd mem_rd C123 00 1F 0 00 1
rom48_rd mem_rd 0200 00 1F 0 00 1
ram_4000_wr mem_wr 4567 AA 1F 0 00 1
ram_8000_rd mem_rd 8001 00 1F 0 00 1
rom_wr mem_wr 0000 55 1F 0 00 1
trdos_in m1 3D00 00 1F 0 00 1
trdos_rom mem_rd 1000 00 1F 0 00 1
trdos_out m1 8000 00 1F 0 00 1
rom_after mem_rd 1000 00 1F 0 00 1
m48_page_wr io_wr 7FFD 07 1F 0 00 0
m48_ignored mem_rd C000 00 1F 0 00 1
lock_wr io_wr 7FFD 24 1F 0 00 1
locked_wr io_wr 7FFD 17 1F 0 00 1
ram_locked mem_rd C000 00 1F 0 00 1
trdos_128 m1 3D00 00 1F 0 00 1
m48_c000 mem_rd C000 00 1F 0 00 0

/* list.f */
rtl/zx_bus_pkg.sv
rtl/zx_machine_pkg.sv
rtl/cpu_bus.sv
rtl/bus_sampler.sv
rtl/zx_ports.sv
rtl/mem_map.sv
rtl/zx_ula_core.sv
tests/zx_ula_checker.sv
tests/zx_ula_tb.sv

/* tests/zx_ula_tb.sv */
//************************************************************
// zx_ula_tb clocks and resets the ULA core, replays the
// vector file as Z80 bus accesses and reports the result.
//************************************************************
`timescale 1ns/1ps
`default_nettype none

module zx_ula_tb
    import zx_machine_pkg::*;
();

    localparam int MAX_VECTORS = 64;
    localparam VECTOR_FILE = "tests/zx_ula_vectors.txt";

    logic        clk28;
    logic        rst_n;
    logic [15:0] xa;
    wire  [7:0]  xd;
    logic [7:0]  xd_drive;
    logic        xd_en;
    logic        n_rd;
    logic        n_wr;
    logic        n_mreq;
    logic        n_iorq;
    logic        n_m1;
    machine_t    machine;
    logic [4:0]  kd;
    logic        tape_in;
    logic [4:0]  joy;
    wire  [3:0]  ra;
    wire         n_romcs;
    wire  [16:0] va;
    wire         n_vrd;
    wire         n_vwr;
    wire  [2:0]  border;
    wire         beeper;
    wire         tape_out;
    wire         trdos;
    logic        start;
    wire  [31:0] tests_done;
    wire  [31:0] error_count;

    int          num_vectors = 0;
    int          bad_vectors = 0;
    int          cycle_limit = 0;
    int          cycles = 0;
    logic [2:0]  v_kind [MAX_VECTORS];
    logic [15:0] v_addr [MAX_VECTORS];
    logic [7:0]  v_data [MAX_VECTORS];
    logic [4:0]  v_kd   [MAX_VECTORS];
    logic        v_tape [MAX_VECTORS];
    logic [4:0]  v_joy  [MAX_VECTORS];
    logic        v_mach [MAX_VECTORS];

    assign xd = xd_en ? xd_drive : 8'hzz;  // cpu side of the data bus.

    zx_ula_core u_dut (
        .clk28 (clk28), .rst_n (rst_n), .xa (xa), .xd (xd),
        .n_rd (n_rd), .n_wr (n_wr), .n_mreq (n_mreq), .n_iorq (n_iorq), .n_m1 (n_m1),
        .machine (machine), .kd (kd), .tape_in (tape_in), .joy (joy),
        .ra (ra), .n_romcs (n_romcs), .va (va), .n_vrd (n_vrd), .n_vwr (n_vwr),
        .border (border), .beeper (beeper), .tape_out (tape_out), .trdos (trdos)
    );

    zx_ula_checker u_checker (
        .clk28 (clk28), .start (start), .xd (xd), .ra (ra), .n_romcs (n_romcs),
        .va (va), .n_vrd (n_vrd), .n_vwr (n_vwr), .border (border), .beeper (beeper),
        .tape_out (tape_out), .trdos (trdos),
        .tests_done (tests_done), .error_count (error_count)
    );

    function automatic logic [2:0] kind_code(input logic [8*8-1:0] kind);
        case (kind)
            "io_wr":  return 3'd0;
            "io_rd":  return 3'd1;
            "mem_rd": return 3'd2;
            "mem_wr": return 3'd3;
            "m1":     return 3'd4;
            default:  return 3'd7;
        endcase
    endfunction

    task automatic load_vectors;
        int              fd;
        int              n;
        logic [8*80-1:0] line;
        logic [8*16-1:0] name;
        logic [8*8-1:0]  kind;
        logic [15:0]     addr;
        logic [7:0]      data;
        logic [4:0]      kd_v;
        logic            tape_v;
        logic [4:0]      joy_v;
        logic            mach_v;
        fd = $fopen(VECTOR_FILE, "r");
        if (fd == 0) begin
            $display("cannot open the vector file %0s", VECTOR_FILE);
        end else begin
            while (!$feof(fd) && num_vectors < MAX_VECTORS) begin
                if ($fgets(line, fd) != 0) begin
                    n = $sscanf(line, "%s %s %h %h %h %h %h %h",
                                name, kind, addr, data, kd_v, tape_v, joy_v, mach_v);
                    if (n == 8 && name != "#") begin
                        if (kind_code(kind) == 3'd7) begin
                            $display("vector %0s has an unknown access kind", name);
                            bad_vectors++;
                        end
                        v_kind[num_vectors] = kind_code(kind);
                        v_addr[num_vectors] = addr;
                        v_data[num_vectors] = data;
                        v_kd[num_vectors]   = kd_v;
                        v_tape[num_vectors] = tape_v;
                        v_joy[num_vectors]  = joy_v;
                        v_mach[num_vectors] = mach_v;
                        num_vectors++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // runs on a falling edge with 4 strobe cycles and 2 idle cycles.
    task automatic run_access(input int i);
        xa      = v_addr[i];
        kd      = v_kd[i];
        tape_in = v_tape[i];
        joy     = v_joy[i];
        machine = machine_t'(v_mach[i]);
        start   = 1'b1;
        case (v_kind[i])
            3'd0: begin
                n_iorq   = 1'b0;
                n_wr     = 1'b0;
                xd_drive = v_data[i];
                xd_en    = 1'b1;
            end
            3'd1: begin
                n_iorq = 1'b0;
                n_rd   = 1'b0;
            end
            3'd2: begin
                n_mreq = 1'b0;
                n_rd   = 1'b0;
            end
            3'd3: begin
                n_mreq   = 1'b0;
                n_wr     = 1'b0;
                xd_drive = v_data[i];
                xd_en    = 1'b1;
            end
            3'd4: begin
                n_m1   = 1'b0;
                n_mreq = 1'b0;
                n_rd   = 1'b0;
            end
            default: ;
        endcase
        @(negedge clk28);
        start = 1'b0;
        repeat (3) @(negedge clk28);
        n_rd   = 1'b1;
        n_wr   = 1'b1;
        n_mreq = 1'b1;
        n_iorq = 1'b1;
        n_m1   = 1'b1;
        xd_en  = 1'b0;
        repeat (2) @(negedge clk28);
    endtask

    initial begin
        clk28 = 1'b0;
        forever #2 clk28 = ~clk28;
    end

    initial begin : main
        int i;
        rst_n    = 1'b0;
        xa       = 16'h0000;
        xd_drive = 8'h00;
        xd_en    = 1'b0;
        n_rd     = 1'b1;
        n_wr     = 1'b1;
        n_mreq   = 1'b1;
        n_iorq   = 1'b1;
        n_m1     = 1'b1;
        machine  = MACHINE_128;
        kd       = 5'h1F;
        tape_in  = 1'b0;
        joy      = 5'h00;
        start    = 1'b0;
        load_vectors();
        if (num_vectors == 0) begin
            $display("no vectors were read, nothing to run");
            $display("=== FAIL ===");
            $finish;
        end else begin
            cycle_limit = num_vectors * 6 + 50;
            repeat (4) @(negedge clk28);
            rst_n = 1'b1;
            for (i = 0; i < num_vectors; i++)
                run_access(i);
            wait (tests_done == num_vectors);
            $display("%0d tests run, %0d errors, %0d bad vectors",
                     tests_done, error_count, bad_vectors);
            if (error_count == 0 && bad_vectors == 0)
                $display("=== PASS ===");
            else
                $display("=== FAIL ===");
            $finish;
        end
    end

    always @(posedge clk28) begin
        cycles <= cycles + 1;
        if (cycle_limit != 0 && cycles >= cycle_limit) begin
            $display("timeout: the vector run did not finish in %0d cycles", cycle_limit);
            $display("=== FAIL ===");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* tests/zx_ula_checker.sv */
//************************************************************
// zx_ula_checker follows the vector file with its own ULA
// model and compares the DUT pins against it.
//************************************************************
`timescale 1ns/1ps
`default_nettype none

module zx_ula_checker
    import zx_machine_pkg::*;
(
    input  wire        clk28,
    input  wire        start,
    input  wire [7:0]  xd,
    input  wire [3:0]  ra,
    input  wire        n_romcs,
    input  wire [16:0] va,
    input  wire        n_vrd,
    input  wire        n_vwr,
    input  wire [2:0]  border,
    input  wire        beeper,
    input  wire        tape_out,
    input  wire        trdos,
    output int         tests_done,
    output int         error_count
);

    logic [2:0] m_border;
    logic       m_tape_out;
    logic       m_beeper;
    logic [2:0] m_ram_page;
    logic       m_rom_page;
    logic       m_lock;
    logic       m_trdos;
    int         test_errors;

    function automatic logic [3:0] rom_bank(input logic m128);
        if (m_trdos)
            return ROM_BANK_TRDOS;
        else if (!m128 || m_rom_page)
            return ROM_BANK_48;
        else
            return ROM_BANK_128;
    endfunction

    // only used above 4000.
    function automatic logic [2:0] ram_page(input logic [15:0] addr, input logic m128);
        case (addr[15:14])
            2'b01:   return 3'd5;
            2'b10:   return 3'd2;
            default: return m128 ? m_ram_page : 3'd0;
        endcase
    endfunction

    task automatic compare(input string sig, input logic [16:0] expected,
                           input logic [16:0] actual);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0d ns: %s expected %h actual %h",
                     $time, sig, expected, actual);
            test_errors++;
        end
    endtask

    initial begin : replay
        int              fd;
        int              n;
        logic [8*80-1:0] line;
        logic [8*16-1:0] name;
        logic [8*8-1:0]  kind;
        logic [15:0]     addr;
        logic [7:0]      data;
        logic [4:0]      kd;
        logic            tape_in;
        logic [4:0]      joy;
        logic            m128;
        logic [7:0]      exp_xd;
        logic            is_rd;
        logic            is_mem;
        logic            rom;
        tests_done  = 0;
        error_count = 0;
        m_border    = 3'd0;
        m_tape_out  = 1'b0;
        m_beeper    = 1'b0;
        m_ram_page  = 3'd0;
        m_rom_page  = 1'b0;
        m_lock      = 1'b0;
        m_trdos     = 1'b0;
        fd = $fopen("tests/zx_ula_vectors.txt", "r");
        if (fd == 0)
            $display("checker cannot open the vector file");
        else forever begin
            @(posedge start);
            n = 0;
            while (n != 8 && !$feof(fd)) begin
                if ($fgets(line, fd) != 0) begin
                    n = $sscanf(line, "%s %s %h %h %h %h %h %h",
                                name, kind, addr, data, kd, tape_in, joy, m128);
                    if (name == "#")
                        n = 0;
                end
            end
            test_errors = 0;
            if (kind == "io_wr" && !addr[0]) begin
                m_border   = data[2:0];
                m_tape_out = data[3];
                m_beeper   = data[4];
            end
            if (kind == "io_wr" && !addr[15] && !addr[1] && m128 && !m_lock) begin
                m_ram_page = data[2:0];
                m_rom_page = data[4];
                m_lock     = data[5];
            end
            if (kind == "m1") begin
                if (addr[15:14] != 2'b00)
                    m_trdos = 1'b0;
                else if (addr[15:8] == 8'h3D && rom_bank(m128) == ROM_BANK_48)
                    m_trdos = 1'b1;
            end
            is_rd  = kind == "mem_rd" || kind == "m1";
            is_mem = is_rd || kind == "mem_wr";
            rom    = addr[15:14] == 2'b00;
            if (kind == "io_rd" && !addr[0])
                exp_xd = {1'b1, tape_in, 1'b1, kd};
            else if (kind == "io_rd" && addr[7:0] == 8'h1F)
                exp_xd = {3'b000, joy};
            else if (kind == "io_wr" || kind == "mem_wr")
                exp_xd = data;  // driven by the cpu side.
            else
                exp_xd = 8'hzz;
            repeat (4) @(posedge clk28);
            #1;
            compare("xd", exp_xd, xd);
            compare("n_romcs", !(is_rd && rom), n_romcs);
            compare("n_vrd", !(is_rd && !rom), n_vrd);
            compare("n_vwr", !(kind == "mem_wr" && !rom), n_vwr);
            if (is_mem && rom)
                compare("ra", rom_bank(m128), ra);
            if (is_mem && !rom)
                compare("va", {ram_page(addr, m128), addr[13:0]}, va);
            @(posedge clk28);
            #1;
            compare("border", m_border, border);
            compare("tape_out", m_tape_out, tape_out);
            compare("beeper", m_beeper, beeper);
            compare("trdos", m_trdos, trdos);
            if (test_errors == 0)
                $display("test %0s (%0s): ok", name, kind);
            else
                $display("test %0s (%0s): %0d mismatches", name, kind, test_errors);
            error_count = error_count + test_errors;
            tests_done  = tests_done + 1;
        end
    end

endmodule

`default_nettype wire

/* rtl/zx_ula_core.sv */
//**********************************************************
// zx_ula_core is the reduced ULA top with bus sampling, port
// registers and memory mapping on the Z80 pins.
//**********************************************************
`timescale 1ns/1ps
`default_nettype none

module zx_ula_core
    import zx_machine_pkg::*;
(
    input  logic        clk28,
    input  logic        rst_n,
    input  logic [15:0] xa,
    inout  wire  [7:0]  xd,
    input  logic        n_rd,
    input  logic        n_wr,
    input  logic        n_mreq,
    input  logic        n_iorq,
    input  logic        n_m1,
    input  machine_t    machine,
    input  logic [4:0]  kd,
    input  logic        tape_in,
    input  logic [4:0]  joy,
    output logic [3:0]  ra,
    output logic        n_romcs,
    output logic [16:0] va,
    output logic        n_vrd,
    output logic        n_vwr,
    output logic [2:0]  border,
    output logic        beeper,
    output logic        tape_out,
    output logic        trdos
);

    paging_t    paging;
    logic [7:0] port_dout;
    logic       port_dout_active;

    cpu_bus bus ();

    bus_sampler u_sampler (
        .clk28  (clk28),
        .rst_n  (rst_n),
        .xa     (xa),
        .xd     (xd),
        .n_rd   (n_rd),
        .n_wr   (n_wr),
        .n_mreq (n_mreq),
        .n_iorq (n_iorq),
        .n_m1   (n_m1),
        .bus    (bus.sampler)
    );

    zx_ports u_ports (
        .clk28            (clk28),
        .rst_n            (rst_n),
        .bus              (bus.consumer),
        .machine          (machine),
        .kd               (kd),
        .tape_in          (tape_in),
        .joy              (joy),
        .border           (border),
        .tape_out         (tape_out),
        .beeper           (beeper),
        .paging           (paging),
        .port_dout        (port_dout),
        .port_dout_active (port_dout_active)
    );

    mem_map u_map (
        .clk28            (clk28),
        .rst_n            (rst_n),
        .bus              (bus.consumer),
        .machine          (machine),
        .paging           (paging),
        .port_dout        (port_dout),
        .port_dout_active (port_dout_active),
        .xd               (xd),
        .ra               (ra),
        .n_romcs          (n_romcs),
        .va               (va),
        .n_vrd            (n_vrd),
        .n_vwr            (n_vwr),
        .trdos            (trdos)
    );

endmodule

`default_nettype wire

/* rtl/mem_map.sv */
//**********************************************************
// mem_map does the ROM and RAM bank mapping, TR-DOS entry
// detect, memory strobes and the CPU data bus driver.
//**********************************************************
`timescale 1ns/1ps
`default_nettype none

module mem_map
    import zx_bus_pkg::*;
    import zx_machine_pkg::*;
(
    input  logic              clk28,
    input  logic              rst_n,
    cpu_bus.consumer          bus,
    input  machine_t          machine,
    input  paging_t           paging,
    input  logic [DATA_W-1:0] port_dout,
    input  logic              port_dout_active,
    inout  wire  [DATA_W-1:0] xd,
    output logic [3:0]        ra,
    output logic              n_romcs,
    output logic [16:0]       va,
    output logic              n_vrd,
    output logic              n_vwr,
    output logic              trdos
);

    logic       rom_area;
    logic [3:0] rom_bank;
    logic [2:0] ram_page;
    logic       basic48_paged;
    logic       m1_fetch;

    assign rom_area = bus.a[15:14] == 2'b00;

    always_comb begin
        if (trdos)
            rom_bank = ROM_BANK_TRDOS;
        else if (machine == MACHINE_48)
            rom_bank = ROM_BANK_48;
        else if (paging.rom_page)
            rom_bank = ROM_BANK_48;
        else
            rom_bank = ROM_BANK_128;
    end

    assign basic48_paged = rom_bank == ROM_BANK_48;

    always_comb begin
        case (bus.a[15:14])
            2'b01:   ram_page = RAM_PAGE_4000;
            2'b10:   ram_page = RAM_PAGE_8000;
            2'b11:   ram_page = (machine == MACHINE_48) ? 3'd0 : paging.ram_page;
            default: ram_page = 3'd0;  // va is unused in the rom area.
        endcase
    end

    assign ra      = rom_bank;
    assign va      = {ram_page, bus.a[RAM_OFS_W-1:0]};
    assign n_romcs = ~(bus.mreq & bus.rd & rom_area);  // rom is read only.
    assign n_vrd   = ~(bus.mreq & bus.rd & ~rom_area);
    assign n_vwr   = ~(bus.mreq & bus.wr & ~rom_area);

    // opcode fetch at the start of a memory cycle.
    assign m1_fetch = bus.mreq_rise & bus.m1;

    always_ff @(posedge clk28 or negedge rst_n) begin
        if (!rst_n)
            trdos <= 1'b0;
        else if (m1_fetch && !rom_area)
            trdos <= 1'b0;
        else if (m1_fetch && bus.a[15:8] == TRDOS_ENTRY_PAGE && basic48_paged)
            trdos <= 1'b1;
    end

    assign xd = (port_dout_active && bus.rd && bus.iorq) ? port_dout : {DATA_W{1'bz}};

endmodule

`default_nettype wire

/* rtl/zx_ports.sv */
//**********************************************************
// zx_ports decodes ULA ports FE, 1F and 7FFD, holds the
// border/sound and paging registers and sources read data.
//**********************************************************
`timescale 1ns/1ps
`default_nettype none

module zx_ports
    import zx_bus_pkg::*;
    import zx_machine_pkg::*;
(
    input  logic              clk28,
    input  logic              rst_n,
    cpu_bus.consumer          bus,
    input  machine_t          machine,
    input  logic [4:0]        kd,
    input  logic              tape_in,
    input  logic [4:0]        joy,
    output logic [2:0]        border,
    output logic              tape_out,
    output logic              beeper,
    output paging_t           paging,
    output logic [DATA_W-1:0] port_dout,
    output logic              port_dout_active
);

    logic fe_hit;
    logic kempston_hit;
    logic p7ffd_hit;
    logic io_wr;
    logic io_wr_q;
    logic io_wr_start;

    assign fe_hit       = (bus.a & PORT_FE_MASK) == '0;
    assign kempston_hit = bus.a[7:0] == PORT_KEMPSTON;
    assign p7ffd_hit    = (bus.a & PORT_7FFD_MASK) == '0;

    // one register write per strobe.
    assign io_wr       = bus.ioreq & bus.wr;
    assign io_wr_start = io_wr & ~io_wr_q;

    always_ff @(posedge clk28 or negedge rst_n) begin
        if (!rst_n)
            io_wr_q <= 1'b0;
        else
            io_wr_q <= io_wr;
    end

    always_ff @(posedge clk28 or negedge rst_n) begin
        if (!rst_n) begin
            border   <= 3'd0;
            tape_out <= 1'b0;
            beeper   <= 1'b0;
        end else if (io_wr_start && fe_hit) begin
            border   <= bus.d[2:0];
            tape_out <= bus.d[3];
            beeper   <= bus.d[4];
        end
    end

    // once locked, only reset opens paging again.
    always_ff @(posedge clk28 or negedge rst_n) begin
        if (!rst_n) begin
            paging <= PAGING_RESET;
        end else if (io_wr_start && p7ffd_hit && machine == MACHINE_128 && !paging.lock) begin
            paging.ram_page   <= bus.d[2:0];
            paging.video_page <= bus.d[3];
            paging.rom_page   <= bus.d[4];
            paging.lock       <= bus.d[5];
        end
    end

    // fe wins over kempston on an even address.
    always_comb begin
        if (fe_hit)
            port_dout = FE_UNUSED_BITS | {1'b0, tape_in, 1'b0, kd};
        else
            port_dout = {3'b000, joy};
    end

    assign port_dout_active = bus.ioreq & bus.rd & (fe_hit | kempston_hit);

endmodule

`default_nettype wire

/* rtl/bus_sampler.sv */
//**********************************************************
// bus_sampler registers the Z80 pins once per clk28 and
// turns the active low strobes into bus flags.
//**********************************************************
`timescale 1ns/1ps
`default_nettype none

module bus_sampler
    import zx_bus_pkg::*;
(
    input  logic              clk28,
    input  logic              rst_n,
    input  logic [ADDR_W-1:0] xa,
    input  logic [DATA_W-1:0] xd,
    input  logic              n_rd,
    input  logic              n_wr,
    input  logic              n_mreq,
    input  logic              n_iorq,
    input  logic              n_m1,
    cpu_bus.sampler           bus
);

    // address and data pins sampled every cycle.
    always_ff @(posedge clk28) begin
        bus.a <= xa;
        bus.d <= xd;
    end

    always_ff @(posedge clk28 or negedge rst_n) begin
        if (!rst_n) begin
            bus.iorq      <= 1'b0;
            bus.mreq      <= 1'b0;
            bus.m1        <= 1'b0;
            bus.rd        <= 1'b0;
            bus.wr        <= 1'b0;
            bus.ioreq     <= 1'b0;
            bus.mreq_rise <= 1'b0;
        end else begin
            bus.iorq      <= ~n_iorq;
            bus.mreq      <= ~n_mreq;
            bus.m1        <= ~n_m1;
            bus.rd        <= ~n_rd;
            bus.wr        <= ~n_wr;
            bus.ioreq     <= ~n_iorq & n_m1;      // iorq with m1 is an int ack.
            bus.mreq_rise <= ~n_mreq & ~bus.mreq; // compare against the old sample.
        end
    end

endmodule

`default_nettype wire

/* rtl/cpu_bus.sv */
//**********************************************************
// cpu_bus carries the sampled Z80 bus with active high flags.
//**********************************************************
`timescale 1ns/1ps
`default_nettype none

interface cpu_bus;

    logic [15:0] a;
    logic [7:0]  d;
    logic        iorq;
    logic        mreq;
    logic        m1;
    logic        rd;
    logic        wr;
    logic        ioreq;      // io cycle that is no int ack.
    logic        mreq_rise;  // first sampled cycle of mreq.

    modport sampler (
        output a, d, iorq, mreq, m1, rd, wr, ioreq, mreq_rise
    );

    modport consumer (
        input a, d, iorq, mreq, m1, rd, wr, ioreq, mreq_rise
    );

endinterface

`default_nettype wire

/* rtl/zx_machine_pkg.sv */
//**********************************************************
// zx machine definitions for the model select, the 7FFD
// paging state and the ROM/RAM bank numbers.
//**********************************************************
`default_nettype none

package zx_machine_pkg;

    typedef enum logic {
        MACHINE_48  = 1'b0,
        MACHINE_128 = 1'b1
    } machine_t;

    // field order follows bits 5..0 of port 7FFD.
    typedef struct packed {
        logic       lock;
        logic       rom_page;
        logic       video_page;
        logic [2:0] ram_page;
    } paging_t;

    localparam logic [3:0] ROM_BANK_128   = 4'd0;
    localparam logic [3:0] ROM_BANK_48    = 4'd1;
    localparam logic [3:0] ROM_BANK_TRDOS = 4'd2;

    localparam logic [2:0] RAM_PAGE_4000 = 3'd5;  // screen page.
    localparam logic [2:0] RAM_PAGE_8000 = 3'd2;

    localparam paging_t PAGING_RESET = '0;

endpackage

`default_nettype wire

/* rtl/zx_bus_pkg.sv */
//**********************************************************
// zx bus definitions with the Z80 bus widths, the ULA port
// decode masks and the fixed bits of the port reads.
//**********************************************************
`default_nettype none

package zx_bus_pkg;

    localparam int ADDR_W    = 16;
    localparam int DATA_W    = 8;
    localparam int RAM_OFS_W = 14;  // offset inside a 16K page.

    // port FE answers to any even address.
    localparam logic [ADDR_W-1:0] PORT_FE_MASK = 16'h0001;

    // 128K paging port decoded on A15 and A1 only.
    localparam logic [ADDR_W-1:0] PORT_7FFD_MASK = 16'h8002;

    // kempston joystick decodes the full low byte.
    localparam logic [7:0] PORT_KEMPSTON = 8'h1F;

    // high byte of the TR-DOS entry points in the 48 ROM.
    localparam logic [7:0] TRDOS_ENTRY_PAGE = 8'h3D;

    // bits 7 and 5 of an FE read float high.
    localparam logic [DATA_W-1:0] FE_UNUSED_BITS = 8'hA0;

endpackage

`default_nettype wire
